/* design/dualIssue_settings.svh */
`ifndef DUALISSUE_SETTINGS_SVH
`define DUALISSUE_SETTINGS_SVH

`define XLEN_BITS       32
`define REG_INDEX_BITS  5
`define REG_COUNT       32

`define OPCODE_OP       7'b0110011
`define OPCODE_OP_IMM   7'b0010011

`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SR       3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

`define FUNCT7_ALT      7'b0100000 // sub / sra

`endif

/* design/dualIssuePkg.sv */
`default_nettype none

`include "dualIssue_settings.svh"

package dualIssuePkg;

    typedef logic [`XLEN_BITS-1:0] regWord;
    typedef logic [`REG_INDEX_BITS-1:0] regIndex;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluOp;

    // lane A is the earlier instruction of the pair
    typedef struct packed {
        logic [31:0] instA;
        logic [31:0] instB;
    } issuePacket;

    // ------------------------------
    typedef struct packed {
        logic    writeEnable;
        regIndex dest;
        regIndex src1;
        regIndex src2;
        logic    useImm;    // op-imm form
        regWord  imm;       // sign-extended I-type
        aluOp    op;
    } decodedLane;

    typedef struct packed {
        logic       valid;
        decodedLane laneA;
        decodedLane laneB;
    } decodedPacket;

    // ------------------------------
    typedef struct packed {
        logic    writeEnable;
        regIndex dest;
        regWord  value;
    } laneResult;

    typedef struct packed {
        logic      valid;
        laneResult laneA;
        laneResult laneB;
    } resultPacket;

endpackage

`default_nettype wire

/* design/laneAlu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dualIssue_settings.svh"

module laneAlu (
    input  wire dualIssuePkg::aluOp   op,
    input  wire dualIssuePkg::regWord operandA,
    input  wire dualIssuePkg::regWord operandB,
    output      dualIssuePkg::regWord result
);

    localparam int SHIFT_BITS = $clog2(`XLEN_BITS);

    logic [SHIFT_BITS-1:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    assign shamt        = operandB[SHIFT_BITS-1:0];
    assign lessSigned   = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;

    always_comb begin
        case (op)
            dualIssuePkg::ALU_ADD:  result = operandA + operandB;
            dualIssuePkg::ALU_SUB:  result = operandA - operandB;
            dualIssuePkg::ALU_SLL:  result = operandA << shamt;
            dualIssuePkg::ALU_SLT:  result = {{(`XLEN_BITS - 1){1'b0}}, lessSigned};
            dualIssuePkg::ALU_SLTU: result = {{(`XLEN_BITS - 1){1'b0}}, lessUnsigned};
            dualIssuePkg::ALU_XOR:  result = operandA ^ operandB;
            dualIssuePkg::ALU_SRL:  result = operandA >> shamt;
            dualIssuePkg::ALU_SRA:  result = $signed(operandA) >>> shamt; // keeps sign
            dualIssuePkg::ALU_OR:   result = operandA | operandB;
            dualIssuePkg::ALU_AND:  result = operandA & operandB;
            default:                result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/packetDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dualIssue_settings.svh"

module packetDecode (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      issueValid,
    input  wire dualIssuePkg::issuePacket  issue,
    output      dualIssuePkg::decodedPacket decoded
);

    logic validQ;
    dualIssuePkg::decodedLane laneAQ;
    dualIssuePkg::decodedLane laneBQ;

    function automatic dualIssuePkg::decodedLane decodeLane(input logic [31:0] inst);
        dualIssuePkg::decodedLane lane;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic isOp;
        logic isOpImm;
        opcode  = inst[6:0];
        funct3  = inst[14:12];
        funct7  = inst[31:25];
        isOp    = (opcode == `OPCODE_OP);
        isOpImm = (opcode == `OPCODE_OP_IMM);

        lane.dest   = inst[11:7];
        lane.src1   = inst[19:15];
        lane.src2   = inst[24:20];
        lane.useImm = isOpImm;
        lane.imm    = {{(`XLEN_BITS - 12){inst[31]}}, inst[31:20]};
        // anything else retires without a write
        lane.writeEnable = (isOp || isOpImm) && (lane.dest != '0);

        lane.op = dualIssuePkg::ALU_ADD;
        case (funct3)
            `FUNCT3_ADD:  lane.op = (isOp && funct7 == `FUNCT7_ALT) ? dualIssuePkg::ALU_SUB
                                                                     : dualIssuePkg::ALU_ADD;
            `FUNCT3_SLL:  lane.op = dualIssuePkg::ALU_SLL;
            `FUNCT3_SLT:  lane.op = dualIssuePkg::ALU_SLT;
            `FUNCT3_SLTU: lane.op = dualIssuePkg::ALU_SLTU;
            `FUNCT3_XOR:  lane.op = dualIssuePkg::ALU_XOR;
            `FUNCT3_SR:   lane.op = (funct7 == `FUNCT7_ALT) ? dualIssuePkg::ALU_SRA
                                                            : dualIssuePkg::ALU_SRL;
            `FUNCT3_OR:   lane.op = dualIssuePkg::ALU_OR;
            `FUNCT3_AND:  lane.op = dualIssuePkg::ALU_AND;
        endcase
        return lane;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            validQ <= 1'b0;
        else
            validQ <= issueValid;
    end

    always_ff @(posedge clock) begin
        if (issueValid) begin
            laneAQ <= decodeLane(issue.instA);
            laneBQ <= decodeLane(issue.instB);
        end
    end

    assign decoded = '{valid: validQ, laneA: laneAQ, laneB: laneBQ};

    // a strobed packet carries defined instruction words
    issueKnown: assert property (@(posedge clock) disable iff (reset)
        issueValid |-> !$isunknown(issue));

endmodule

`default_nettype wire

/* design/packetExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module packetExecute (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire dualIssuePkg::decodedPacket  decoded,
    output      dualIssuePkg::regIndex [3:0] readIndex,
    input  wire dualIssuePkg::regWord  [3:0] readData,
    output      dualIssuePkg::resultPacket   executed
);

    dualIssuePkg::regWord [3:0] operand;    // A src1, A src2, B src1, B src2
    dualIssuePkg::regWord aluInA2;
    dualIssuePkg::regWord aluInB2;
    dualIssuePkg::regWord resultA;
    dualIssuePkg::regWord resultB;

    logic validQ;
    dualIssuePkg::laneResult laneAQ;
    dualIssuePkg::laneResult laneBQ;

    // previous packet is not in the register file yet
    function automatic dualIssuePkg::regWord forward(
        input dualIssuePkg::regIndex     src,
        input dualIssuePkg::regWord      fileData,
        input dualIssuePkg::resultPacket prev
    );
        if (prev.valid && prev.laneB.writeEnable && prev.laneB.dest == src)
            return prev.laneB.value;   // B is later, so it wins
        if (prev.valid && prev.laneA.writeEnable && prev.laneA.dest == src)
            return prev.laneA.value;
        return fileData;
    endfunction

    assign readIndex = {decoded.laneB.src2, decoded.laneB.src1,
                        decoded.laneA.src2, decoded.laneA.src1};

    always_comb begin
        for (int i = 0; i < 4; i++)
            operand[i] = forward(readIndex[i], readData[i], executed);
    end

    assign aluInA2 = decoded.laneA.useImm ? decoded.laneA.imm : operand[1];
    assign aluInB2 = decoded.laneB.useImm ? decoded.laneB.imm : operand[3];

    // ------------------------------
    laneAlu aluA (
        .op       (decoded.laneA.op),
        .operandA (operand[0]),
        .operandB (aluInA2),
        .result   (resultA)
    );

    laneAlu aluB (
        .op       (decoded.laneB.op),
        .operandA (operand[2]),
        .operandB (aluInB2),
        .result   (resultB)
    );

    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            validQ <= 1'b0;
        else
            validQ <= decoded.valid;
    end

    always_ff @(posedge clock) begin
        if (decoded.valid) begin
            laneAQ <= '{writeEnable: decoded.laneA.writeEnable,
                        dest: decoded.laneA.dest, value: resultA};
            laneBQ <= '{writeEnable: decoded.laneB.writeEnable,
                        dest: decoded.laneB.dest, value: resultB};
        end
    end

    assign executed = '{valid: validQ, laneA: laneAQ, laneB: laneBQ};

    // register file reads come back defined for a live packet
    readDataKnown: assert property (@(posedge clock) disable iff (reset)
        decoded.valid |-> !$isunknown(readData));

endmodule

`default_nettype wire

/* design/writeback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dualIssue_settings.svh"

module writeback (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire dualIssuePkg::regIndex [3:0] readIndex,
    output      dualIssuePkg::regWord  [3:0] readData,
    input  wire dualIssuePkg::resultPacket   executed,
    output      dualIssuePkg::resultPacket   retire
);

    dualIssuePkg::regWord regFile [`REG_COUNT];

    logic retireValid;
    dualIssuePkg::laneResult retireA;
    dualIssuePkg::laneResult retireB;

    // four async read ports
    always_comb begin
        for (int i = 0; i < 4; i++)
            readData[i] = (readIndex[i] == '0) ? '0 : regFile[readIndex[i]];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < `REG_COUNT; r++)
                regFile[r] <= '0;
        end else if (executed.valid) begin
            if (executed.laneA.writeEnable)
                regFile[executed.laneA.dest] <= executed.laneA.value;
            if (executed.laneB.writeEnable)
                regFile[executed.laneB.dest] <= executed.laneB.value; // last one wins
        end
    end

    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            retireValid <= 1'b0;
        else
            retireValid <= executed.valid;
    end

    always_ff @(posedge clock) begin
        if (executed.valid) begin
            retireA <= executed.laneA;
            retireB <= executed.laneB;
        end
    end

    assign retire = '{valid: retireValid, laneA: retireA, laneB: retireB};

    zeroNeverWritten: assert property (@(posedge clock) disable iff (reset)
        executed.valid |-> !(executed.laneA.writeEnable && executed.laneA.dest == '0) &&
                           !(executed.laneB.writeEnable && executed.laneB.dest == '0));

endmodule

`default_nettype wire

/* design/dualIssueCore.sv */
`timescale 1ns/1ps
`default_nettype none

module dualIssueCore (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      issueValid,
    input  wire dualIssuePkg::issuePacket  issue,
    output      dualIssuePkg::resultPacket retire
);

    dualIssuePkg::decodedPacket decoded;
    dualIssuePkg::resultPacket executed;
    dualIssuePkg::regIndex [3:0] readIndex;
    dualIssuePkg::regWord  [3:0] readData;

    packetDecode decode0 (
        .clock      (clock),
        .reset      (reset),
        .issueValid (issueValid),
        .issue      (issue),
        .decoded    (decoded)
    );

    packetExecute execute0 (
        .clock     (clock),
        .reset     (reset),
        .decoded   (decoded),
        .readIndex (readIndex),
        .readData  (readData),
        .executed  (executed)
    );

    writeback writeback0 (
        .clock     (clock),
        .reset     (reset),
        .readIndex (readIndex),
        .readData  (readData),
        .executed  (executed),
        .retire    (retire)
    );

endmodule

`default_nettype wire

/* test/tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsrState = 32'd71847;
logic [31:0] modelRegs [`REG_COUNT] = '{default: '0};

typedef struct packed {
    logic [6:0]  opcode;
    logic        useImm;
    logic [2:0]  funct3;
    logic        alt;       // sub / sra / srai
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
} laneSpec;

function automatic logic [31:0] takeBits(input int count);
    logic [31:0] bits;
    logic feedback;
    bits = '0;
    for (int i = 0; i < count; i++) begin
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        bits      = {bits[30:0], feedback};
    end
    return bits;
endfunction

function automatic laneSpec randomLane();
    laneSpec s;
    logic [2:0] pick;
    logic altBit;
    pick     = 3'(takeBits(3));
    s.funct3 = 3'(takeBits(3));
    altBit   = 1'(takeBits(1));
    s.rd     = 5'(takeBits(3));    // x0..x7 only
    s.rs1    = 5'(takeBits(3));
    s.rs2    = 5'(takeBits(3));
    s.imm    = 12'(takeBits(12));
    if (pick <= 3'd3) begin
        s.opcode = `OPCODE_OP;
        s.useImm = 1'b0;
        s.alt    = altBit && (s.funct3 == `FUNCT3_ADD || s.funct3 == `FUNCT3_SR);
    end else if (pick <= 3'd6) begin
        s.opcode = `OPCODE_OP_IMM;
        s.useImm = 1'b1;
        s.alt    = altBit && (s.funct3 == `FUNCT3_SR);
        if (s.funct3 == `FUNCT3_SLL || s.funct3 == `FUNCT3_SR)
            s.imm = {(s.alt ? `FUNCT7_ALT : 7'b0), s.imm[4:0]};
    end else begin
        // load, store, branch, lui
        case (2'(takeBits(2)))
            2'd0:    s.opcode = 7'b0000011;
            2'd1:    s.opcode = 7'b0100011;
            2'd2:    s.opcode = 7'b1100011;
            default: s.opcode = 7'b0110111;
        endcase
        s.useImm = 1'b0;
        s.alt    = 1'b0;
    end
    return s;
endfunction

function automatic logic [31:0] encodeLane(input laneSpec s);
    if (s.opcode == `OPCODE_OP)
        return {(s.alt ? `FUNCT7_ALT : 7'b0), s.rs2, s.rs1, s.funct3, s.rd, s.opcode};
    return {s.imm, s.rs1, s.funct3, s.rd, s.opcode};   // I-type layout
endfunction

function automatic logic [31:0] referenceAlu(input logic [2:0] funct3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] aSigned;
    logic [31:0] r;
    aSigned = a;
    case (funct3)
        `FUNCT3_ADD:  r = alt ? a - b : a + b;
        `FUNCT3_SLL:  r = a << b[4:0];
        `FUNCT3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `FUNCT3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
        `FUNCT3_XOR:  r = a ^ b;
        `FUNCT3_OR:   r = a | b;
        `FUNCT3_AND:  r = a & b;
        default: begin
            if (alt)
                r = aSigned >>> b[4:0];
            else
                r = a >> b[4:0];
        end
    endcase
    return r;
endfunction

function automatic dualIssuePkg::laneResult modelLane(input laneSpec s);
    dualIssuePkg::laneResult r;
    logic [31:0] a;
    logic [31:0] b;
    a = modelRegs[s.rs1];
    b = s.useImm ? {{20{s.imm[11]}}, s.imm} : modelRegs[s.rs2];
    r.writeEnable = (s.opcode == `OPCODE_OP || s.opcode == `OPCODE_OP_IMM) && s.rd != 5'd0;
    r.dest  = s.rd;
    r.value = referenceAlu(s.funct3, s.alt, a, b);
    return r;
endfunction

// both lanes see the state from before the packet
task automatic modelPacket(input laneSpec a, input laneSpec b,
                           output dualIssuePkg::resultPacket want);
    want.valid = 1'b1;
    want.laneA = modelLane(a);
    want.laneB = modelLane(b);
    if (want.laneA.writeEnable)
        modelRegs[want.laneA.dest] = want.laneA.value;
    if (want.laneB.writeEnable)
        modelRegs[want.laneB.dest] = want.laneB.value;  // B wins
endtask

`endif

/* test/dualIssueTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dualIssue_settings.svh"

module dualIssueTb;

    localparam int PACKET_COUNT = 400;
    localparam int RESET_CYCLES = 5;

    logic clock = 1'b0;
    logic reset;
    logic issueValid;
    dualIssuePkg::issuePacket issue;
    dualIssuePkg::resultPacket retire;

    int edgeCount = 0;
    dualIssuePkg::resultPacket expectQueue[$];
    int expectEdge[$];    // clock edge where each retire is due

    `include "tbModel.svh"

    dualIssueCore dut0 (
        .clock      (clock),
        .reset      (reset),
        .issueValid (issueValid),
        .issue      (issue),
        .retire     (retire)
    );

    always #5 clock = ~clock;

    always @(posedge clock)
        edgeCount <= edgeCount + 1;

    // ------------------------------
    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else
            abortRun($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, want));
    endtask

    task automatic checkLane(input string lane, input dualIssuePkg::laneResult got,
                             input dualIssuePkg::laneResult want);
        checkField({"retire.", lane, ".writeEnable"}, 32'(got.writeEnable),
                   32'(want.writeEnable));
        if (want.writeEnable) begin    // dest and value only matter on a write
            checkField({"retire.", lane, ".dest"}, 32'(got.dest), 32'(want.dest));
            checkField({"retire.", lane, ".value"}, got.value, want.value);
        end
    endtask

    // called once per falling edge
    task automatic checkRetire();
        dualIssuePkg::resultPacket want;
        int wantEdge;
        assert (!$isunknown(retire.valid)) else
            abortRun("retire.valid is unknown");
        if (retire.valid) begin
            assert (expectQueue.size() > 0) else
                abortRun("retire strobe seen with no packet outstanding");
            want     = expectQueue.pop_front();
            wantEdge = expectEdge.pop_front();
            assert (edgeCount == wantEdge) else
                abortRun($sformatf("packet retired at clock edge %0d instead of edge %0d",
                                   edgeCount, wantEdge));
            checkLane("laneA", retire.laneA, want.laneA);
            checkLane("laneB", retire.laneB, want.laneB);
        end
    endtask

    // ------------------------------
    initial begin
        laneSpec specA;
        laneSpec specB;
        dualIssuePkg::resultPacket want;
        int gap;
        reset      = 1'b1;
        issueValid = 1'b0;
        issue      = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int p = 0; p < PACKET_COUNT; p++) begin
            gap = int'(takeBits(2));
            repeat (gap) begin
                checkRetire();
                issueValid = 1'b0;
                @(negedge clock);
            end
            checkRetire();
            specA = randomLane();
            specB = randomLane();
            issue = '{instA: encodeLane(specA), instB: encodeLane(specB)};
            issueValid = 1'b1;
            modelPacket(specA, specB, want);
            expectQueue.push_back(want);
            expectEdge.push_back(edgeCount + 1 + 2);   // issuing edge plus two
            @(negedge clock);
        end
        issueValid = 1'b0;

        // drain the pipe
        repeat (4) begin
            checkRetire();
            @(negedge clock);
        end
        checkRetire();

        if (expectQueue.size() != 0) begin
            abortRun($sformatf("%0d packets never retired", expectQueue.size()));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin
        #(PACKET_COUNT * 5 * 10 + 200);
        abortRun("watchdog expired before the run completed");
    end

endmodule

`default_nettype wire

/* dualIssueCore.f */
+incdir+design
+incdir+test
design/dualIssuePkg.sv
design/laneAlu.sv
design/packetDecode.sv
design/packetExecute.sv
design/writeback.sv
design/dualIssueCore.sv
test/dualIssueTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dualIssueTb \
    -f dualIssueCore.f -o dualIssueSim

if ./obj_dir/dualIssueSim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null; then
    exit 0
else
    exit 1
fi
